// File: Makefile
TOP = fpuCtrlTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing -f project.f --top-module $(TOP) --Mdir obj_dir -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: hdl/divSqrtSequencer.sv
// Divide / square-root busy sequencer
`timescale 1ns/1ps

module divSqrtSequencer import fpuConfigPkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic divStartE,  // one cycle start pulse from E
  output logic divBusy
);

  // cycles left before the result would be ready
  logic [DIV_CNTBITS-1:0] count;

  ////////////////////////////////////////////////////////////
  // latency counter
  ////////////////////////////////////////////////////////////

  // load on start, count down to zero
  // busy from the cycle after start for DIV_CYCLES cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (divStartE) begin
      count <= DIV_CNTBITS'(DIV_CYCLES);
    end else if (divBusy) begin
      count <= count - DIV_CNTBITS'(1);  // one iteration done
    end
  end

  assign divBusy = (count != '0);  // idle at zero

endmodule

// File: hdl/fpuConfigPkg.sv
// FPU configuration constants
package fpuConfigPkg;

  ////////////////////////////////////////////////////////////
  // formats
  ////////////////////////////////////////////////////////////

  // only single and double are built
  // fmt encoding: 0 single, 1 double
  localparam int FMTBITS = 1;  // width of the fmt field

  ////////////////////////////////////////////////////////////
  // divide / square root latency
  ////////////////////////////////////////////////////////////

  // busy cycles after the start pulse
  localparam int DIV_CYCLES = 10;

  // counter wide enough to hold DIV_CYCLES
  localparam int DIV_CNTBITS = $clog2(DIV_CYCLES + 1);

endpackage

// File: hdl/fpuCtrl.sv
// FPU control pipeline
`timescale 1ns/1ps

module fpuCtrl import fpuCtrlPkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic [31:0]  instrD,
  input  logic         validD,
  input  logic [2:0]   frmCsr,
  input  logic [1:0]   statusFs,
  input  fpuStageCtrlT stageCtrl,  // stalls and flushes from hazard unit
  output fpuCtrlWordT  ctrlE,
  output fpuCtrlWordT  ctrlM,
  output fpuCtrlWordT  ctrlW,
  output fpuSrcAdrT    srcAdrE,
  output logic         divStartE   // one pulse per divide
);

  fpuCtrlWordT         ctrlD;
  fpuCtrlWordT         stageIn [STAGES];  // index 0 E, 1 M, 2 W
  fpuCtrlWordT         stageQ  [STAGES];
  logic [STAGES-1:0]   stageStall;
  logic [STAGES-1:0]   stageFlush;
  logic                loadE;      // E takes a new word this edge
  logic                divIssued;  // divide in E already started
  logic                trapM;

  fpuDecoder decoder (
    .instrD   (instrD),
    .frmCsr   (frmCsr),
    .statusFs (statusFs),
    .validD   (validD),
    .ctrlD    (ctrlD)
  );

  ////////////////////////////////////////////////////////////
  // stage registers D/E, E/M, M/W
  ////////////////////////////////////////////////////////////

  assign stageStall = {stageCtrl.stallW, stageCtrl.stallM, stageCtrl.stallE};
  assign stageFlush = {stageCtrl.flushW, stageCtrl.flushM, stageCtrl.flushE};

  assign stageIn[0] = ctrlD;
  assign stageIn[1] = stageQ[0];
  assign stageIn[2] = stageQ[1];

  // flush beats stall, a flushed slot is all zero
  always_ff @(posedge clk) begin
    for (int i = 0; i < STAGES; i++) begin
      if (reset || stageFlush[i]) stageQ[i] <= '0;
      else if (!stageStall[i])    stageQ[i] <= stageIn[i];
    end
  end

  assign ctrlE = stageQ[0];
  assign ctrlM = stageQ[1];
  assign ctrlW = stageQ[2];

  // source addresses follow the E word
  assign loadE = stageCtrl.flushE | ~stageCtrl.stallE;

  always_ff @(posedge clk) begin
    if (loadE) begin
      srcAdrE <= '{adr1: instrD[19:15], adr2: instrD[24:20], adr3: instrD[31:27]};
    end
  end

  ////////////////////////////////////////////////////////////
  // divide start
  ////////////////////////////////////////////////////////////

  // E word is killed by the trap flush, so no start then
  assign trapM = ctrlM.valid & ctrlM.illegal;

  assign divStartE = ctrlE.valid & ctrlE.divOp & ~divIssued & ~trapM;

  always_ff @(posedge clk) begin
    if (reset)          divIssued <= 1'b0;
    else if (loadE)     divIssued <= 1'b0;  // new word in E
    else if (divStartE) divIssued <= 1'b1;  // hold until it leaves
  end

endmodule

// File: hdl/fpuCtrlPkg.sv
// FPU control types
package fpuCtrlPkg;
  import fpuConfigPkg::*;

  // stage registers after decode: E, M, W
  localparam int STAGES = 3;

  ////////////////////////////////////////////////////////////
  // opcodes and selects
  ////////////////////////////////////////////////////////////

  // major opcodes handled by the fpu
  typedef enum logic [6:0] {
    opLoadFp  = 7'b0000111,  // flw / fld
    opStoreFp = 7'b0100111,  // fsw / fsd
    opFmadd   = 7'b1000011,
    opFmsub   = 7'b1000111,
    opFnmsub  = 7'b1001011,
    opFnmadd  = 7'b1001111,
    opFp      = 7'b1010011   // everything else, split by funct7
  } fpOpcodeT;

  // final result select
  //         fp path     int path
  typedef enum logic [1:0] {
    resOther    = 2'b00,  // other      compare
    resPostProc = 2'b01,  // postproc   convert
    resStore    = 2'b10,  // store      class
    resMove     = 2'b11   //            move
  } fResSelT;

  // which unit feeds the post processor
  typedef enum logic [1:0] {
    ppCvt = 2'b00,
    ppDiv = 2'b01,
    ppFma = 2'b10
  } postProcSelT;

  ////////////////////////////////////////////////////////////
  // per-stage bundles
  ////////////////////////////////////////////////////////////

  // control word carried down the pipe
  typedef struct packed {
    logic               valid;      // slot holds an instruction
    logic               fRegWrite;  // writes fp register file
    logic               fWriteInt;  // writes integer register file
    fResSelT            fResSel;
    postProcSelT        postProcSel;
    logic [2:0]         opCtrl;     // op variant within the unit
    logic [2:0]         frm;        // resolved rounding mode
    logic [FMTBITS-1:0] fmt;
    logic               divOp;      // needs the divide sequencer
    logic               illegal;    // traps when it reaches M
  } fpuCtrlWordT;

  // source register addresses, rs1 rs2 rs3
  typedef struct packed {
    logic [4:0] adr1;
    logic [4:0] adr2;
    logic [4:0] adr3;
  } fpuSrcAdrT;

  // hazard unit outputs
  typedef struct packed {
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushE;
    logic flushM;
    logic flushW;
  } fpuStageCtrlT;

endpackage

// File: hdl/fpuCtrlTop.sv
// FPU control path top level
`timescale 1ns/1ps

module fpuCtrlTop import fpuCtrlPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] instrD,
  input  logic        validD,
  input  logic [2:0]  frmCsr,
  input  logic [1:0]  statusFs,
  input  logic        stallReq,
  output logic        stallD,
  output fpuCtrlWordT ctrlE,
  output fpuCtrlWordT ctrlM,
  output fpuCtrlWordT ctrlW,
  output fpuSrcAdrT   srcAdrE,
  output logic        divBusy,
  output logic        illegalTrap
);

  fpuStageCtrlT stageCtrl;  // hazard unit to pipeline
  logic         divStartE;

  // decode and stage registers
  fpuCtrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .instrD    (instrD),
    .validD    (validD),
    .frmCsr    (frmCsr),
    .statusFs  (statusFs),
    .stageCtrl (stageCtrl),
    .ctrlE     (ctrlE),
    .ctrlM     (ctrlM),
    .ctrlW     (ctrlW),
    .srcAdrE   (srcAdrE),
    .divStartE (divStartE)
  );

  // divider latency model
  divSqrtSequencer divSeq (
    .clk       (clk),
    .reset     (reset),
    .divStartE (divStartE),
    .divBusy   (divBusy)
  );

  fpuHazardUnit hazard (
    .stallReq    (stallReq),
    .validD      (validD),
    .divStartE   (divStartE),
    .divBusy     (divBusy),
    .ctrlM       (ctrlM),
    .stageCtrl   (stageCtrl),
    .stallD      (stallD),
    .illegalTrap (illegalTrap)
  );

endmodule

// File: hdl/fpuDecoder.sv
// FPU instruction decoder
`timescale 1ns/1ps

module fpuDecoder import fpuCtrlPkg::*; (
  input  logic [31:0] instrD,
  input  logic [2:0]  frmCsr,    // rounding mode from csr
  input  logic [1:0]  statusFs,  // fpu enable state
  input  logic        validD,
  output fpuCtrlWordT ctrlD
);

  fpOpcodeT    opcode;
  logic [4:0]  funct5;  // funct7 without the fmt bits
  logic [2:0]  funct3;
  logic [4:0]  rs2;
  logic        legal;
  fpuCtrlWordT dec;

  assign opcode = fpOpcodeT'(instrD[6:0]);
  assign funct5 = instrD[31:27];
  assign funct3 = instrD[14:12];
  assign rs2    = instrD[24:20];

  ////////////////////////////////////////////////////////////
  // decode table
  ////////////////////////////////////////////////////////////

  always_comb begin
    dec     = '0;
    legal   = 1'b1;
    dec.fmt = instrD[25];  // fmt field, op-fp and r4 forms
    case (opcode)
      opLoadFp, opStoreFp: begin
        legal         = (funct3 == 3'b010) || (funct3 == 3'b011);  // w or d only
        dec.fRegWrite = (opcode == opLoadFp);
        dec.fResSel   = resStore;
        dec.fmt       = funct3[0];  // width comes from funct3 here
      end
      opFmadd, opFmsub, opFnmsub, opFnmadd: begin
        legal           = ~instrD[26];  // no half / quad
        dec.fRegWrite   = 1'b1;
        dec.fResSel     = resPostProc;
        dec.postProcSel = ppFma;
        dec.opCtrl      = {1'b0, instrD[3:2]};  // 00 madd 01 msub 10 nmsub 11 nmadd
      end
      opFp: begin
        legal = ~instrD[26];
        case (funct5)
          5'b00000, 5'b00001, 5'b00010: begin  // add sub mul
            dec.fRegWrite   = 1'b1;
            dec.fResSel     = resPostProc;
            dec.postProcSel = ppFma;
            dec.opCtrl      = (funct5 == 5'b00010) ? 3'b100 : {2'b11, funct5[0]};
          end
          5'b00011, 5'b01011: begin  // div, sqrt
            legal           = legal && (funct5[3] == 1'b0 || rs2 == 5'd0);
            dec.fRegWrite   = 1'b1;
            dec.fResSel     = resPostProc;
            dec.postProcSel = ppDiv;
            dec.opCtrl      = {2'b00, funct5[3]};  // 1 for sqrt
            dec.divOp       = 1'b1;
          end
          5'b00100: begin  // sign inject
            legal         = legal && (funct3 <= 3'b010);
            dec.fRegWrite = 1'b1;
            dec.opCtrl    = funct3;  // sgnj sgnjn sgnjx
          end
          5'b00101: begin  // min / max
            legal         = legal && (funct3[2:1] == 2'b00);
            dec.fRegWrite = 1'b1;
            dec.opCtrl    = funct3[0] ? 3'b101 : 3'b110;
          end
          5'b10100: begin  // compare, result to int reg
            dec.fWriteInt = 1'b1;
            case (funct3)
              3'b010:  dec.opCtrl = 3'b010;  // feq
              3'b001:  dec.opCtrl = 3'b001;  // flt
              3'b000:  dec.opCtrl = 3'b011;  // fle
              default: legal = 1'b0;
            endcase
          end
          5'b11100: begin  // class or move fp -> int
            legal         = legal && (rs2 == 5'd0) && (funct3[2:1] == 2'b00);
            dec.fWriteInt = 1'b1;
            dec.fResSel   = funct3[0] ? resStore : resMove;
          end
          5'b11110: begin  // move int -> fp
            legal         = legal && (rs2 == 5'd0) && (funct3 == 3'b000);
            dec.fRegWrite = 1'b1;
            dec.opCtrl    = 3'b011;
          end
          5'b11000, 5'b11010: begin  // int converts, funct5[1] set for int -> fp
            legal           = legal && (rs2[4:2] == 3'b000);
            dec.fRegWrite   = funct5[1];
            dec.fWriteInt   = ~funct5[1];
            dec.fResSel     = resPostProc;
            dec.postProcSel = ppCvt;
            dec.opCtrl      = {funct5[1], rs2[1], ~rs2[0]};  // {to fp, 64 bit, signed}
          end
          5'b01000: begin  // fcvt.s.d / fcvt.d.s
            legal           = legal && (rs2[4:1] == 4'd0) && (rs2[0] != instrD[25]);
            dec.fRegWrite   = 1'b1;
            dec.fResSel     = resPostProc;
            dec.postProcSel = ppCvt;
            dec.opCtrl      = {2'b00, instrD[25]};  // destination format
            dec.fmt         = rs2[0];               // source format from rs2
          end
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    // 111 means dynamic, take the csr value
    dec.frm = (funct3 == 3'b111) ? frmCsr : funct3;
    legal   = legal && (statusFs != 2'b00);  // fpu off, nothing is legal
  end

  // illegal words carry only valid and illegal
  always_comb begin
    ctrlD = dec;
    if (!legal) begin
      ctrlD         = '0;
      ctrlD.illegal = 1'b1;
    end
    ctrlD.valid = validD;
  end

endmodule

// File: hdl/fpuHazardUnit.sv
// FPU hazard unit
`timescale 1ns/1ps

module fpuHazardUnit import fpuCtrlPkg::*; (
  input  logic         stallReq,   // external back-pressure
  input  logic         validD,
  input  logic         divStartE,
  input  logic         divBusy,
  input  fpuCtrlWordT  ctrlM,
  output fpuStageCtrlT stageCtrl,
  output logic         stallD,
  output logic         illegalTrap
);

  logic divHold;    // divide occupies E
  logic stallE;
  logic trapFlush;  // trap acts once back-pressure is gone

  assign illegalTrap = ctrlM.valid & ctrlM.illegal;
  assign trapFlush   = illegalTrap & ~stallReq;

  assign divHold = divStartE | divBusy;
  assign stallE  = stallReq | divHold;

  // bubble into M only when M itself moves
  // trap kills M, E and D words behind the illegal one
  assign stageCtrl.stallE = stallE;
  assign stageCtrl.stallM = stallReq;
  assign stageCtrl.stallW = stallReq;
  assign stageCtrl.flushE = (~validD & ~stallE) | trapFlush;  // empty D slot
  assign stageCtrl.flushM = (divHold & ~stallReq) | trapFlush;
  assign stageCtrl.flushW = trapFlush;

  assign stallD = stallE;  // D holds whenever E holds

endmodule

// File: project.f
hdl/fpuConfigPkg.sv
hdl/fpuCtrlPkg.sv
hdl/fpuDecoder.sv
hdl/divSqrtSequencer.sv
hdl/fpuHazardUnit.sv
hdl/fpuCtrl.sv
hdl/fpuCtrlTop.sv
verification/fpuCtrlTb.sv

// File: verification/fpuCtrlStim.txt
// instr frmCsr statusFs | fRegWrite fWriteInt fResSel postProcSel opCtrl frm fmt divOp illegal
// one instruction per line, all values hex
// arithmetic
003100D3 0 3 1 0 1 2 6 0 0 0 0
0A42F353 3 3 1 0 1 2 7 3 1 0 0
10109153 0 3 1 0 1 2 4 1 0 0 0
182081D3 0 3 1 0 1 1 0 0 0 1 0
203110D3 0 3 1 0 0 0 1 1 0 0 0
// half precision, illegal
043100D3 0 3 0 0 0 0 0 0 0 0 1
2A3110D3 0 3 1 0 0 0 5 1 1 0 0
A03120D3 0 3 0 1 0 0 2 2 0 0 0
5A0272D3 2 3 1 0 1 1 1 2 1 1 0
A23100D3 0 3 0 1 0 0 3 0 1 0 0
// fpu off
003100D3 0 0 0 0 0 0 0 0 0 0 1
// class and moves
E00110D3 0 3 0 1 2 0 0 1 0 0 0
E00100D3 0 3 0 1 3 0 0 0 0 0 0
F00100D3 0 1 1 0 0 0 3 0 0 0 0
// integer add, not fp
00000033 0 3 0 0 0 0 0 0 0 0 1
// converts
C00110D3 0 3 0 1 1 0 1 1 0 0 0
D23170D3 4 3 1 0 1 0 6 4 1 0 0
401100D3 0 3 1 0 1 0 0 0 1 0 0
// load
00812087 0 3 1 0 2 0 0 2 0 0 0
// sign inject with bad funct3
203130D3 0 3 0 0 0 0 0 0 0 0 1
// store and fused forms
00313827 0 3 0 0 2 0 0 3 1 0 0
203100C3 0 3 1 0 1 2 0 0 0 0 0
2A3170CF 1 3 1 0 1 2 3 1 1 0 0
203120C7 0 3 1 0 1 2 1 2 0 0 0

// File: verification/fpuCtrlTb.sv
// FPU control path testbench
`timescale 1ns/1ps

module fpuCtrlTb import fpuConfigPkg::*, fpuCtrlPkg::*; ();

  localparam int NUMVEC     = 24;  // lines in the stim file
  localparam int FIELDS     = 12;  // hex values per line
  localparam int STEP_LIMIT = 40;  // cycles before a wait gives up

  logic        clk;
  logic        reset;
  logic [31:0] instrD;
  logic        validD;
  logic [2:0]  frmCsr;
  logic [1:0]  statusFs;
  logic        stallReq;
  logic        stallD;
  fpuCtrlWordT ctrlE;
  fpuCtrlWordT ctrlM;
  fpuCtrlWordT ctrlW;
  fpuSrcAdrT   srcAdrE;
  logic        divBusy;
  logic        illegalTrap;

  logic [31:0] stimMem [NUMVEC*FIELDS];
  fpuCtrlWordT expQ [$];  // words accepted at D, oldest first
  int          idQ [$];   // stim line of each queued word
  logic [31:0] lcgState;
  logic        mLoaded;   // M took a new word at the last edge
  int          valueErrors;
  int          otherErrors;
  int          checked;

  fpuCtrlTop DUT (
    .clk         (clk),
    .reset       (reset),
    .instrD      (instrD),
    .validD      (validD),
    .frmCsr      (frmCsr),
    .statusFs    (statusFs),
    .stallReq    (stallReq),
    .stallD      (stallD),
    .ctrlE       (ctrlE),
    .ctrlM       (ctrlM),
    .ctrlW       (ctrlW),
    .srcAdrE     (srcAdrE),
    .divBusy     (divBusy),
    .illegalTrap (illegalTrap)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // hard stop for a hung pipe
  initial begin
    #500000;
    $display("simulation watchdog expired before the test finished");
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // expected control word from one stim line
  function automatic fpuCtrlWordT expWord(input int idx);
    fpuCtrlWordT w;
    int          b;
    b             = idx * FIELDS;
    w             = '0;
    w.valid       = 1'b1;
    w.fRegWrite   = stimMem[b+3][0];
    w.fWriteInt   = stimMem[b+4][0];
    w.fResSel     = fResSelT'(stimMem[b+5][1:0]);
    w.postProcSel = postProcSelT'(stimMem[b+6][1:0]);
    w.opCtrl      = stimMem[b+7][2:0];
    w.frm         = stimMem[b+8][2:0];
    w.fmt         = stimMem[b+9][FMTBITS-1:0];
    w.divOp       = stimMem[b+10][0];
    w.illegal     = stimMem[b+11][0];
    return w;
  endfunction

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // scoreboard side, runs on outputs settled since the last edge
  task automatic checkStages();
    fpuCtrlWordT want;
    int          id;
    if (mLoaded && ctrlM.valid) begin
      if (expQ.size() == 0) begin
        otherErrors++;
        $display("a valid word reached M while nothing was expected");
      end else begin
        want = expQ.pop_front();
        id   = idQ.pop_front();
        checked++;
        if (ctrlM !== want) begin
          valueErrors++;
          $display("FAIL ctrlM line %0d: got %h expected %h", id, ctrlM, want);
        end
        if (illegalTrap !== want.illegal) begin
          valueErrors++;
          $display("FAIL illegalTrap line %0d: got %h expected %h", id, illegalTrap,
                   want.illegal);
        end
      end
    end
    if (ctrlW.valid && ctrlW.illegal) begin
      otherErrors++;
      $display("an illegal word reached W");
    end
  endtask

  // one clock: check, drive on the falling edge, then track D
  task automatic runCycle(input logic v, input logic sr, input int idx, output logic taken);
    int b;
    b = idx * FIELDS;
    @(negedge clk);
    checkStages();
    instrD   = stimMem[b];
    frmCsr   = stimMem[b+1][2:0];
    statusFs = stimMem[b+2][1:0];
    validD   = v;
    stallReq = sr;
    #1;
    taken = v & ~stallD;
    if (illegalTrap && !stallReq) begin
      // trap kills E word and D slot
      if (ctrlE.valid) begin
        if (expQ.size() == 0) begin
          otherErrors++;
          $display("trap found a valid E word that was never accepted");
        end else begin
          expQ.delete(0);
          idQ.delete(0);
        end
      end
    end else if (taken) begin
      expQ.push_back(expWord(idx));
      idQ.push_back(idx);
    end
    mLoaded = ~sr;  // M moves unless held
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic        taken;
    logic        holding;
    logic        v;
    logic        sr;
    logic [31:0] r;
    int          cnt;
    int          hold;
    int          busyCnt;
    int          stallCnt;
    int          idx;
    int          guard;
    fpuSrcAdrT   wantAdr;
    reset       = 1'b1;
    instrD      = '0;
    validD      = 1'b0;
    frmCsr      = '0;
    statusFs    = 2'b11;
    stallReq    = 1'b0;
    lcgState    = 32'h89d8;
    mLoaded     = 1'b1;
    valueErrors = 0;
    otherErrors = 0;
    checked     = 0;
    $readmemh("verification/fpuCtrlStim.txt", stimMem);
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    if (ctrlE.valid || ctrlM.valid || ctrlW.valid || divBusy || stallD || illegalTrap) begin
      otherErrors++;
      $display("pipeline not idle after reset");
    end

    // no stalls, fadd timing through E and W
    runCycle(1'b1, 1'b0, 0, taken);
    if (!taken) begin
      otherErrors++;
      $display("first instruction was not accepted");
    end
    cnt = 0;
    while (!ctrlE.valid && cnt < STEP_LIMIT) begin
      runCycle(1'b0, 1'b0, 0, taken);
      cnt++;
    end
    if (cnt != 1) begin
      valueErrors++;
      $display("FAIL ctrlE latency: got %h expected %h", cnt, 1);
    end
    if (ctrlE !== expWord(0)) begin
      valueErrors++;
      $display("FAIL ctrlE: got %h expected %h", ctrlE, expWord(0));
    end
    wantAdr = '{adr1: stimMem[0][19:15], adr2: stimMem[0][24:20], adr3: stimMem[0][31:27]};
    if (srcAdrE !== wantAdr) begin
      valueErrors++;
      $display("FAIL srcAdrE: got %h expected %h", srcAdrE, wantAdr);
    end
    while (!ctrlW.valid && cnt < STEP_LIMIT) begin
      runCycle(1'b0, 1'b0, 0, taken);
      cnt++;
    end
    if (cnt != 3) begin
      valueErrors++;
      $display("FAIL ctrlW latency: got %h expected %h", cnt, 3);
    end
    if (ctrlW !== expWord(0)) begin
      valueErrors++;
      $display("FAIL ctrlW: got %h expected %h", ctrlW, expWord(0));
    end

    // fdiv held in E by the sequencer
    runCycle(1'b1, 1'b0, 3, taken);
    cnt = 0;
    while (!ctrlE.valid && cnt < STEP_LIMIT) begin
      runCycle(1'b0, 1'b0, 3, taken);
      cnt++;
    end
    hold     = 0;
    busyCnt  = 0;
    stallCnt = 0;
    while (ctrlE.valid && hold < STEP_LIMIT) begin
      if (divBusy) busyCnt++;
      if (stallD) stallCnt++;
      hold++;
      runCycle(1'b0, 1'b0, 3, taken);
    end
    // start cycle, busy cycles, one release cycle
    if (hold != DIV_CYCLES + 2) begin
      valueErrors++;
      $display("FAIL ctrlE.valid cycles on divide: got %h expected %h", hold,
               DIV_CYCLES + 2);
    end
    if (busyCnt != DIV_CYCLES) begin
      valueErrors++;
      $display("FAIL divBusy cycles: got %h expected %h", busyCnt, DIV_CYCLES);
    end
    if (stallCnt != DIV_CYCLES + 1) begin
      valueErrors++;
      $display("FAIL stallD cycles: got %h expected %h", stallCnt, DIV_CYCLES + 1);
    end

    // whole stim file under random stalls and gaps
    idx     = 0;
    holding = 1'b0;
    guard   = 0;
    while (idx < NUMVEC && guard < 3000) begin
      r  = nextRand();
      sr = (r[18:16] == 3'd0);
      v  = holding | (r[25:24] != 2'd0);  // must hold an unaccepted word
      runCycle(v, sr, idx, taken);
      if (taken) begin
        idx++;
        holding = 1'b0;
      end else begin
        holding = v;
      end
      guard++;
    end
    if (idx < NUMVEC) begin
      otherErrors++;
      $display("random phase ran out of cycles before all lines were accepted");
    end

    // drain
    guard = 0;
    while (expQ.size() != 0 && guard < STEP_LIMIT) begin
      runCycle(1'b0, 1'b0, 0, taken);
      guard++;
    end
    if (expQ.size() != 0) begin
      otherErrors++;
      $display("accepted words never reached M");
    end

    $display("errors: %0d value, %0d other; %0d words checked", valueErrors, otherErrors,
             checked);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
